// File: compile.f
+incdir+include
source/fetch_pkg.sv
source/fetch_bus_if.sv
source/fetch_unit.sv
source/icache.sv
source/fetch_top.sv
verification/axi_rom_model.sv
verification/fetch_properties.sv
verification/fetch_tb.sv

// File: Makefile
# Verilator build and run for the fetch front end

VERILATOR   ?= verilator
TOP         ?= fetch_tb
MDIR        ?= obj_dir
FILELIST    ?= compile.f
ERROR_LIMIT ?= 1000
VFLAGS      ?= --timing --assert
PASS_TEXT   ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(MDIR) -o V$(TOP)
	@out="$$(./$(MDIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(MDIR)

// File: verification/fetch_tb.sv
`default_nettype none

`include "fetch_params.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int clock_period   = 100;
    localparam int drive_delay    = 10;
    localparam int num_tests      = 6;
    localparam int insts_per_test = 25;
    localparam int timeout_cycles = num_tests * insts_per_test * 40;

    // Events from later stages
    localparam int ev_none     = 0;
    localparam int ev_redirect = 1;
    localparam int ev_hold     = 2;
    localparam int ev_both     = 3;

    localparam addr_t loop_base = 32'h3000_4000;

    logic  clock;
    logic  reset;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  hold;
    logic  inst_valid;
    logic  inst_ready;
    addr_t pc;
    inst_t inst;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    inst_t rdata;
    logic  rvalid;
    logic  rready;
    logic  rlast;

    // Reference model of the pc stream
    addr_t expected_pc;
    logic  pend_redirect;
    logic  pend_hold;
    addr_t pend_target;

    int delivered;
    int ar_count;
    int tb_errors;
    int tests_done;
    int mark_insts;
    int mark_errors;

    fetch_top dut (.*);

    axi_rom_model #(.drive_delay(drive_delay)) rom (.*);

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, fetch stream stalled", timeout_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic inst_t rom_word(input addr_t addr);
        return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
    endfunction

    // Hold first, then a latched redirect, then one in the handshake cycle
    function automatic addr_t pick_next_pc();
        if (hold || pend_hold) return expected_pc;
        if (pend_redirect) return pend_target;
        if (redirect_valid) return redirect_pc;
        return expected_pc + 32'd4;
    endfunction

    // Word-aligned targets in two small regions
    function automatic addr_t random_target();
        addr_t base;
        base = ($urandom % 2 == 0) ? 32'h3000_0100 : 32'h3000_2000;
        return base + 32'(($urandom % 32) * 4);
    endfunction

    function automatic int total_errors();
        return tb_errors + int'(dut.props.failures);
    endfunction

    // --------------------
    // Monitor
    // --------------------

    // Values at the falling edge are the ones the next rising edge samples
    always @(negedge clock) begin
        if (!reset) begin
            if (inst_valid && inst_ready) begin
                assert (pc == expected_pc) else begin
                    $display("ERR %0t: pc %h, expected %h", $time, pc, expected_pc);
                    tb_errors++;
                end
                assert (inst == rom_word(expected_pc)) else begin
                    $display("ERR %0t: inst %h at pc %h, expected %h",
                        $time, inst, expected_pc, rom_word(expected_pc));
                    tb_errors++;
                end
                delivered++;
                expected_pc   = pick_next_pc();
                pend_redirect = 1'b0;
                pend_hold     = 1'b0;
            end else if (!pend_redirect && !pend_hold) begin
                pend_redirect = redirect_valid;
                pend_hold     = hold;
                pend_target   = redirect_pc;
            end
            if (arvalid && arready) begin
                ar_count++;
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    task automatic step();
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic set_event(input int kind, input addr_t target);
        redirect_valid = (kind == ev_redirect || kind == ev_both);
        hold           = (kind == ev_hold || kind == ev_both);
        redirect_pc    = target;
    endtask

    // Early event lands while the fetch is in flight, late one with the handshake
    task automatic take_instruction(input int gap, input int early, input int late,
                                    input addr_t late_target);
        if (early != ev_none) begin
            set_event(early, random_target());
            step();
            set_event(ev_none, '0);
        end
        while (!inst_valid) step();
        repeat (gap) step();
        inst_ready = 1'b1;
        set_event(late, late_target);
        step();
        inst_ready = 1'b0;
        set_event(ev_none, '0);
    endtask

    task automatic report_test(input string name);
        tests_done++;
        $display("test %s: %0d instructions, %0d errors",
            name, delivered - mark_insts, total_errors() - mark_errors);
        mark_insts  = delivered;
        mark_errors = total_errors();
    endtask

    // Mode 0 plain, 1 redirects, 2 holds, 3 long back-pressure
    task automatic run_test(input string name, input int count, input int mode);
        int gap;
        int early;
        int late;
        for (int i = 0; i < count; i++) begin
            gap   = $urandom % 3;
            early = ev_none;
            late  = ev_none;
            if (mode == 1) begin
                early = (i % 4 == 0 || i % 4 == 3) ? ev_redirect : ev_none;
                late  = (i % 4 == 1 || i % 4 == 3) ? ev_redirect : ev_none;
            end else if (mode == 2) begin
                early = (i % 5 == 1) ? ev_hold : (i % 5 == 4) ? ev_redirect : ev_none;
                late  = (i % 5 == 0 || i % 5 == 4) ? ev_hold
                      : (i % 5 == 3) ? ev_both : ev_none;
            end else if (mode == 3) begin
                gap = 3 + $urandom % 4;
            end
            take_instruction(gap, early, late, random_target());
        end
        report_test(name);
    endtask

    // Two lines fetched three times, later passes must all hit
    task automatic run_loop_test();
        int ar_mark;
        ar_mark = 0;
        take_instruction(0, ev_none, ev_redirect, loop_base);
        for (int pass = 0; pass < 3; pass++) begin
            if (pass == 1) ar_mark = ar_count;
            for (int i = 0; i < 8; i++) begin
                take_instruction($urandom % 2, ev_none,
                    (i == 7) ? ev_redirect : ev_none, loop_base);
            end
        end
        assert (ar_count == ar_mark) else begin
            $display("ERR %0t: %0d refills on cached passes, expected 0",
                $time, ar_count - ar_mark);
            tb_errors++;
        end
        report_test("caching");
    endtask

    initial begin
        void'($urandom(32'h4126_443a));
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        hold           = 1'b0;
        inst_ready     = 1'b0;
        expected_pc    = `RESET_PC;
        pend_redirect  = 1'b0;
        pend_hold      = 1'b0;
        pend_target    = '0;
        delivered      = 0;
        ar_count       = 0;
        tb_errors      = 0;
        tests_done     = 0;
        mark_insts     = 0;
        mark_errors    = 0;

        repeat (10) @(posedge clock);
        #drive_delay;
        reset = 1'b0;
        step();
        report_test("reset");

        run_test("sequential", 20, 0);
        run_test("redirect", 16, 1);
        run_test("hold", 20, 2);
        run_test("backpressure", 12, 3);
        run_loop_test();

        $display("%0d tests, %0d instructions, %0d errors",
            tests_done, delivered, total_errors());
        if (total_errors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/fetch_properties.sv
`default_nettype none

`include "fetch_params.svh"

module fetch_properties
    import fetch_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input logic  inst_valid,
    input logic  inst_ready,
    input addr_t pc,
    input inst_t inst,
    input addr_t araddr,
    input logic  arvalid,
    input logic  arready,
    input logic  rvalid,
    input logic  rready,
    input logic  rlast
);

    int unsigned failures;
    logic        refill_open;
    logic        last_beat;

    initial failures = 0;

    assign last_beat = rvalid && rready && rlast;

    // Opened by the address handshake, closed by the rlast beat
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            refill_open <= 1'b0;
        end else if (arvalid && arready) begin
            refill_open <= 1'b1;
        end else if (last_beat) begin
            refill_open <= 1'b0;
        end
    end

    // --------------------
    // Downstream side
    // --------------------

    reset_quiet: assert property (@(posedge clock)
        $past(reset) |-> !inst_valid && !arvalid && !rready)
        else begin
            failures++;
            $error("inst_valid, arvalid or rready active during or right after reset");
        end

    // Hit path is three cycles from handshake to the next inst_valid
    hit_latency: assert property (@(posedge clock) disable iff (reset)
        $past(inst_valid && inst_ready, 3) && !$past(arvalid)
        |-> inst_valid && !$past(inst_valid) && !$past(inst_valid, 2))
        else begin
            failures++;
            $error("ERR %0t: cache hit did not deliver 3 cycles after handshake", $time);
        end

    miss_latency: assert property (@(posedge clock) disable iff (reset)
        $past(last_beat) || $past(last_beat, 2) |-> !inst_valid)
        else begin
            failures++;
            $error("ERR %0t: inst_valid rose too soon after the last refill beat", $time);
        end

    back_pressure: assert property (@(posedge clock) disable iff (reset)
        $past(inst_valid && !inst_ready)
        |-> inst_valid && $stable(pc) && $stable(inst) && !arvalid)
        else begin
            failures++;
            $error("ERR %0t: pc %h inst %h changed or refill began under back-pressure",
                $time, pc, inst);
        end

    // --------------------
    // AXI read side
    // --------------------

    // Refill starts at the aligned line holding the fetch pc
    ar_aligned: assert property (@(posedge clock) disable iff (reset)
        arvalid |-> araddr == (pc & ~addr_t'(`LINE_WORDS * 4 - 1)))
        else begin
            failures++;
            $error("ERR %0t: araddr %h is not the line of pc %h", $time, araddr, pc);
        end

    ar_stable: assert property (@(posedge clock) disable iff (reset)
        $past(arvalid && !arready) |-> arvalid && $stable(araddr))
        else begin
            failures++;
            $error("arvalid dropped or araddr moved before arready");
        end

    // rready only between the address handshake and the rlast beat
    refill_window: assert property (@(posedge clock) disable iff (reset)
        rready |-> refill_open)
        else begin
            failures++;
            $error("rready active outside a refill burst");
        end

endmodule

bind fetch_top fetch_properties props (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .pc         (pc),
    .inst       (inst),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rlast      (rlast)
);

`default_nettype wire

// File: verification/axi_rom_model.sv
`default_nettype none

`include "fetch_params.svh"

// AXI4 read-only memory for instruction refills
module axi_rom_model
    import fetch_pkg::*;
#(
    parameter int drive_delay = 10
) (
    input  logic  clock,
    input  logic  reset,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output inst_t rdata,
    output logic  rvalid,
    input  logic  rready,
    output logic  rlast
);

    addr_t burst_addr;

    task automatic step();
        @(posedge clock);
        #drive_delay;
    endtask

    // One INCR burst of a full line, with random stalls
    task automatic serve_burst();
        logic  accepted;
        addr_t beat_addr;
        repeat ($urandom % 3) step();
        arready    = 1'b1;
        burst_addr = araddr;
        step();
        arready = 1'b0;
        for (int beat = 0; beat < `LINE_WORDS; beat++) begin
            repeat ($urandom % 3) step();
            beat_addr = burst_addr + 32'(beat * 4);
            // Word address pattern so every word differs
            rdata  = {2'b00, beat_addr[31:2]} ^ 32'hA5A5_0000;
            rvalid = 1'b1;
            rlast  = (beat == `LINE_WORDS - 1);
            do begin
                accepted = rready;
                step();
            end while (!accepted);
            rvalid = 1'b0;
            rlast  = 1'b0;
        end
    endtask

    initial begin
        arready    = 1'b0;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rdata      = '0;
        burst_addr = '0;
        forever begin
            step();
            if (!reset && arvalid) begin
                serve_burst();
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clock,
    input  logic  reset,

    // Downstream stage
    output logic  inst_valid,
    input  logic  inst_ready,
    output addr_t pc,
    output inst_t inst,

    // Later stages
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  hold,

    // AXI4 read channels
    output addr_t araddr,
    output logic  arvalid,
    input  logic  arready,
    input  inst_t rdata,
    input  logic  rvalid,
    output logic  rready,
    input  logic  rlast
);

    fetch_bus_if bus ();

    fetch_unit u_fetch_unit (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hold           (hold),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .pc             (pc),
        .inst           (inst),
        .bus            (bus.requester)
    );

    icache u_icache (
        .clock   (clock),
        .reset   (reset),
        .bus     (bus.responder),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .rlast   (rlast)
    );

endmodule

`default_nettype wire

// File: source/icache.sv
`default_nettype none

`include "fetch_params.svh"

module icache
    import fetch_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    fetch_bus_if.responder bus,
    output addr_t          araddr,
    output logic           arvalid,
    input  logic           arready,
    input  inst_t          rdata,
    input  logic           rvalid,
    output logic           rready,
    input  logic           rlast
);

    // Word offset starts above the byte bits
    localparam int unsigned offset_lsb = 2;
    localparam int unsigned index_lsb  = offset_lsb + $bits(offset_t);
    localparam int unsigned tag_lsb    = index_lsb + $bits(index_t);

    cache_state_t              state;
    logic [`ICACHE_LINES-1:0]  valid_bits;
    tag_t                      tag_array [`ICACHE_LINES];
    inst_t                     data_array [`ICACHE_LINES][`LINE_WORDS];

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    req_fire;
    logic    req_hit;

    addr_t   addr_q;
    tag_t    q_tag;
    index_t  q_index;
    offset_t q_offset;
    offset_t beat;
    logic    beat_fire;

    // --------------------
    // Address split and hit check
    // --------------------

    assign req_tag    = bus.req_addr[tag_lsb +: $bits(tag_t)];
    assign req_index  = bus.req_addr[index_lsb +: $bits(index_t)];
    assign req_offset = bus.req_addr[offset_lsb +: $bits(offset_t)];

    assign q_tag    = addr_q[tag_lsb +: $bits(tag_t)];
    assign q_index  = addr_q[index_lsb +: $bits(index_t)];
    assign q_offset = addr_q[offset_lsb +: $bits(offset_t)];

    assign bus.req_ready = (state == cache_lookup);
    assign req_fire      = bus.req_valid && bus.req_ready;
    assign req_hit       = valid_bits[req_index] && (tag_array[req_index] == req_tag);

    // --------------------
    // AXI read side
    // --------------------

    // Line-aligned burst start
    assign araddr    = {q_tag, q_index, {($bits(offset_t) + offset_lsb){1'b0}}};
    assign arvalid   = (state == cache_refill_address);
    assign rready    = (state == cache_refill_data);
    assign beat_fire = rvalid && rready;

    // --------------------
    // Control
    // --------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= cache_lookup;
            valid_bits     <= '0;
            beat           <= '0;
            bus.resp_valid <= 1'b0;
        end else begin
            bus.resp_valid <= 1'b0;
            case (state)
                cache_lookup: begin
                    if (req_fire) begin
                        if (req_hit) begin
                            bus.resp_valid <= 1'b1;
                        end else begin
                            state <= cache_refill_address;
                        end
                    end
                end
                cache_refill_address: begin
                    if (arready) begin
                        beat  <= '0;
                        state <= cache_refill_data;
                    end
                end
                cache_refill_data: begin
                    if (beat_fire) begin
                        beat <= beat + offset_t'(1);
                        if (rlast) begin
                            valid_bits[q_index] <= 1'b1;
                            state               <= cache_respond;
                        end
                    end
                end
                cache_respond: begin
                    // Line is complete, return the word that missed
                    bus.resp_valid <= 1'b1;
                    state          <= cache_lookup;
                end
                default: state <= cache_lookup;
            endcase
        end
    end

    // --------------------
    // Arrays and payload
    // --------------------

    always_ff @(posedge clock) begin
        if (req_fire) begin
            addr_q <= bus.req_addr;
        end
        if (req_fire && req_hit) begin
            bus.resp_inst <= data_array[req_index][req_offset];
        end
        if (state == cache_respond) begin
            bus.resp_inst <= data_array[q_index][q_offset];
        end
        // Beats arrive in order from word 0
        if (beat_fire) begin
            data_array[q_index][beat] <= rdata;
        end
        if (beat_fire && rlast) begin
            tag_array[q_index] <= q_tag;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`default_nettype none

`include "fetch_params.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           redirect_valid,
    input  addr_t          redirect_pc,
    input  logic           hold,
    output logic           inst_valid,
    input  logic           inst_ready,
    output addr_t          pc,
    output inst_t          inst,
    fetch_bus_if.requester bus
);

    fetch_state_t state;
    logic         handshake;
    logic         redirect_pending;
    logic         hold_pending;
    addr_t        redirect_target;
    addr_t        next_pc;

    assign inst_valid   = (state == fetch_deliver);
    assign handshake    = inst_valid && inst_ready;
    assign bus.req_addr = pc;

    // --------------------
    // Next pc selection
    // --------------------

    // Hold beats any redirect, a latched redirect beats a fresh one
    always_comb begin
        if (hold || hold_pending) begin
            next_pc = pc;
        end else if (redirect_pending) begin
            next_pc = redirect_target;
        end else if (redirect_valid) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // Keep the first redirect or hold seen before delivery
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            redirect_pending <= 1'b0;
            hold_pending     <= 1'b0;
        end else if (handshake) begin
            redirect_pending <= 1'b0;
            hold_pending     <= 1'b0;
        end else if (!redirect_pending && !hold_pending) begin
            redirect_pending <= redirect_valid;
            hold_pending     <= hold;
        end
    end

    always_ff @(posedge clock) begin
        if (!handshake && !redirect_pending && !hold_pending) begin
            redirect_target <= redirect_pc;
        end
    end

    // --------------------
    // Fetch sequencing
    // --------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= fetch_request;
            bus.req_valid <= 1'b0;
            pc            <= `RESET_PC;
        end else begin
            case (state)
                fetch_request: begin
                    // Also raises the very first request after reset
                    bus.req_valid <= 1'b1;
                    if (bus.req_valid && bus.req_ready) begin
                        bus.req_valid <= 1'b0;
                        state         <= fetch_wait;
                    end
                end
                fetch_wait: begin
                    if (bus.resp_valid) begin
                        state <= fetch_deliver;
                    end
                end
                fetch_deliver: begin
                    if (inst_ready) begin
                        pc            <= next_pc;
                        bus.req_valid <= 1'b1;
                        state         <= fetch_request;
                    end
                end
                default: state <= fetch_request;
            endcase
        end
    end

    // Instruction word held stable until taken downstream
    always_ff @(posedge clock) begin
        if (state == fetch_wait && bus.resp_valid) begin
            inst <= bus.resp_inst;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_bus_if.sv
`default_nettype none

// Request and response path between fetch unit and instruction cache
interface fetch_bus_if
    import fetch_pkg::*;
();

    logic  req_valid;
    logic  req_ready;
    addr_t req_addr;

    // One-cycle pulse, always accepted by the requester
    logic  resp_valid;
    inst_t resp_inst;

    modport requester (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  resp_valid,
        input  resp_inst
    );

    modport responder (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output resp_valid,
        output resp_inst
    );

endinterface

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // Address split for the instruction cache
    typedef logic [23:0] tag_t;
    typedef logic [3:0]  index_t;
    typedef logic [1:0]  offset_t;

    typedef enum logic [1:0] {
        fetch_request,
        fetch_wait,
        fetch_deliver
    } fetch_state_t;

    typedef enum logic [1:0] {
        cache_lookup,
        cache_refill_address,
        cache_refill_data,
        cache_respond
    } cache_state_t;

endpackage

`default_nettype wire

// File: include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// --------------------
// Fetch front end constants
// --------------------

// First instruction address after reset
`define RESET_PC 32'h3000_0000

// Direct-mapped cache geometry
`define ICACHE_LINES 16

// Words per line, also the AXI refill burst length
`define LINE_WORDS 4

`endif
